//--- include/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// reservation station depth
`define RS_SIZE 8

// reorder buffer tag width
`define ROB_BITS 4

// datapath width
`define XLEN 32

// load/store unit memory depth in words
`define LSU_MEM_WORDS 64
`define LSU_LATENCY 2 // cycles from load acceptance to done

`endif

//--- src/rv_op_pkg.sv
package rv_op_pkg;

    // major opcodes handled by the integer ALU
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011, // addi, slti, andi, slli ...
        OP_REG = 7'b0110011  // add, sub, sll, sra ...
    } opcode_t;

    // funct3 field from instr[14:12]
    // SUB shares ADD and SRA shares SRL; instr[30] tells them apart
    typedef enum logic [2:0] {
        ADD  = 3'b000,
        SLL  = 3'b001,
        SLT  = 3'b010,
        SLTU = 3'b011,
        XOR  = 3'b100,
        SRL  = 3'b101,
        OR   = 3'b110,
        AND  = 3'b111
    } funct3_t;

endpackage

//--- src/exec_types_pkg.sv
`include "exec_cfg.svh"

package exec_types_pkg;
    import rv_op_pkg::*;

    typedef logic [`XLEN-1:0]                   word_t;
    typedef logic [`ROB_BITS-1:0]               rob_tag_t;
    typedef logic [$clog2(`RS_SIZE)-1:0]        rs_idx_t;
    typedef logic [$clog2(`LSU_MEM_WORDS)-1:0]  lsu_addr_t; // word address

    // one source operand holding a value or the tag it still waits on
    typedef struct packed {
        word_t    value;
        logic     waiting;
        rob_tag_t tag;
    } operand_t;

    typedef struct packed {
        opcode_t  opcode;
        funct3_t  funct3;
        logic     alt;   // instr[30]
        operand_t src1;
        operand_t src2;  // carries the immediate for OP_IMM
        rob_tag_t dest;
    } issue_pkt_t;

    typedef struct packed {
        opcode_t  opcode;
        funct3_t  funct3;
        logic     alt;
        word_t    val1;
        word_t    val2;
        rob_tag_t dest;
    } alu_req_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        logic      is_store;
        lsu_addr_t addr;
        word_t     data;
        rob_tag_t  dest;   // result tag for loads only
    } lsu_req_t;

endpackage

//--- src/rs_entry_select.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module rs_entry_select
    import exec_types_pkg::*;
(
    input  logic [`RS_SIZE-1:0] busy,
    input  logic [`RS_SIZE-1:0] ready,
    output rs_idx_t             issue_idx,
    output logic                dispatch_valid,
    output rs_idx_t             dispatch_idx,
    output logic                full
);

    // scan from the top so the lowest matching index wins
    always_comb begin
        issue_idx    = '0;
        dispatch_idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                issue_idx = rs_idx_t'(i);
            end
            if (ready[i]) begin
                dispatch_idx = rs_idx_t'(i);
            end
        end
    end

    assign dispatch_valid = |ready;
    assign full           = &busy; // no free slot left

endmodule

//--- src/reservation_station.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module reservation_station
    import exec_types_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst,
    input  logic       rdy,
    input  logic       rob_clear,
    input  logic       issue_valid,
    input  issue_pkt_t issue_pkt,
    input  cdb_t       cdb,
    input  logic       alu_busy,
    output logic       rs_full,
    output logic       alu_req_valid,
    output alu_req_t   alu_req
);

    issue_pkt_t          entries [`RS_SIZE];
    logic [`RS_SIZE-1:0] busy_q;
    logic [`RS_SIZE-1:0] ready;

    issue_pkt_t issue_byp;  // incoming packet after cdb bypass
    issue_pkt_t sel_pkt;    // entry picked for dispatch
    rs_idx_t    issue_idx;
    rs_idx_t    dispatch_idx;
    logic       dispatch_valid;
    logic       issue_fire;
    logic       dispatch_fire;

    // capture a broadcast value if the operand is waiting on that tag
    function automatic operand_t snoop(operand_t opnd, cdb_t bus);
        operand_t res;
        res = opnd;
        if (opnd.waiting && bus.valid && (bus.tag == opnd.tag)) begin
            res.value   = bus.value;
            res.waiting = 1'b0;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            ready[i] = busy_q[i] && !entries[i].src1.waiting && !entries[i].src2.waiting;
        end
    end

    rs_entry_select select_i (
        .busy           (busy_q),
        .ready          (ready),
        .issue_idx      (issue_idx),
        .dispatch_valid (dispatch_valid),
        .dispatch_idx   (dispatch_idx),
        .full           (rs_full)
    );

    assign issue_fire    = issue_valid && !rs_full && rdy;
    assign alu_req_valid = dispatch_valid && !alu_busy; // hold while alu result is stuck
    assign dispatch_fire = alu_req_valid && rdy;

    // same-cycle wakeup for a packet arriving with the producer's broadcast
    always_comb begin
        issue_byp      = issue_pkt;
        issue_byp.src1 = snoop(issue_pkt.src1, cdb);
        issue_byp.src2 = snoop(issue_pkt.src2, cdb);
    end

    always_ff @(posedge clk_in) begin
        if (rst || rob_clear) begin
            busy_q <= '0;
        end else if (rdy) begin
            if (issue_fire) begin
                busy_q[issue_idx] <= 1'b1;
            end
            if (dispatch_fire) begin
                busy_q[dispatch_idx] <= 1'b0; // never the slot being issued
            end
        end
    end

    // operand storage and cdb wakeup
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (issue_fire && (issue_idx == rs_idx_t'(i))) begin
                entries[i] <= issue_byp;
            end else if (rdy && busy_q[i]) begin
                entries[i].src1 <= snoop(entries[i].src1, cdb);
                entries[i].src2 <= snoop(entries[i].src2, cdb);
            end
        end
    end

    assign sel_pkt = entries[dispatch_idx];

    always_comb begin
        alu_req.opcode = sel_pkt.opcode;
        alu_req.funct3 = sel_pkt.funct3;
        alu_req.alt    = sel_pkt.alt;
        alu_req.val1   = sel_pkt.src1.value;
        alu_req.val2   = sel_pkt.src2.value;
        alu_req.dest   = sel_pkt.dest;
    end

endmodule

//--- src/int_alu.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module int_alu
    import rv_op_pkg::*;
    import exec_types_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst,
    input  logic     rdy,
    input  logic     rob_clear,
    input  logic     req_valid,
    input  alu_req_t req,
    input  logic     grant,
    output logic     done,
    output logic     busy,
    output cdb_t     result
);

    logic [$clog2(`XLEN)-1:0] shamt;
    logic                     sub_en;
    logic                     accept;
    word_t                    alu_out;

    logic     done_q;
    rob_tag_t held_tag;
    word_t    held_value;

    assign shamt  = req.val2[$clog2(`XLEN)-1:0];
    assign sub_en = (req.opcode == OP_REG) && req.alt; // addi has no sub form

    always_comb begin
        case (req.funct3)
            ADD:     alu_out = sub_en ? (req.val1 - req.val2) : (req.val1 + req.val2);
            SLL:     alu_out = req.val1 << shamt;
            SLT:     alu_out = word_t'($signed(req.val1) < $signed(req.val2));
            SLTU:    alu_out = word_t'(req.val1 < req.val2);
            XOR:     alu_out = req.val1 ^ req.val2;
            SRL: begin
                if (req.alt) begin
                    alu_out = word_t'($signed(req.val1) >>> shamt); // sra / srai
                end else begin
                    alu_out = req.val1 >> shamt;
                end
            end
            OR:      alu_out = req.val1 | req.val2;
            AND:     alu_out = req.val1 & req.val2;
            default: alu_out = '0;
        endcase
    end

    assign busy   = done_q && !grant;
    assign accept = rdy && req_valid && !busy;

    always_ff @(posedge clk_in) begin
        if (rst || rob_clear) begin
            done_q <= 1'b0;
        end else if (rdy) begin
            if (accept) begin
                done_q <= 1'b1;  // new result replaces the granted one
            end else if (grant) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            held_tag   <= req.dest;
            held_value <= alu_out;
        end
    end

    assign done         = done_q;
    assign result.valid = done_q;
    assign result.tag   = held_tag;
    assign result.value = held_value;

endmodule

//--- src/load_store_unit.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module load_store_unit
    import exec_types_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst,
    input  logic     rdy,
    input  logic     rob_clear,
    input  lsu_req_t req,
    input  logic     grant,
    output logic     busy,
    output logic     done,
    output cdb_t     result
);

    localparam int CNT_W = $clog2(`LSU_LATENCY + 1);

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_WAIT,   // counting load latency
        LSU_HOLD    // result waiting for the cdb
    } lsu_state_t;

    word_t      mem [`LSU_MEM_WORDS];
    lsu_state_t state_q;
    logic [CNT_W-1:0] cnt_q;
    rob_tag_t   tag_q;
    word_t      data_q;
    logic       accept;

    assign busy   = (state_q != LSU_IDLE);
    assign accept = rdy && req.valid && !busy;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && req.is_store) begin
            mem[req.addr] <= req.data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst || rob_clear) begin
            state_q <= LSU_IDLE;
            cnt_q   <= '0;
        end else if (rdy) begin
            case (state_q)
                LSU_IDLE: begin
                    if (accept && !req.is_store) begin
                        state_q <= LSU_WAIT;
                        cnt_q   <= CNT_W'(`LSU_LATENCY - 1);
                    end
                end
                LSU_WAIT: begin
                    if (cnt_q == '0) begin
                        state_q <= LSU_HOLD;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                LSU_HOLD: begin
                    if (grant) begin
                        state_q <= LSU_IDLE;
                    end
                end
                default: state_q <= LSU_IDLE;
            endcase
        end
    end

    // load data is read from memory at acceptance
    always_ff @(posedge clk_in) begin
        if (accept && !req.is_store) begin
            tag_q  <= req.dest;
            data_q <= mem[req.addr];
        end
    end

    assign done         = (state_q == LSU_HOLD);
    assign result.valid = done;
    assign result.tag   = tag_q;
    assign result.value = data_q;

endmodule

//--- src/cdb_arbiter.sv
`timescale 1ns/10ps

module cdb_arbiter
    import exec_types_pkg::*;
(
    input  logic clk_in,
    input  logic rst,
    input  logic rdy,
    input  logic alu_done,
    input  cdb_t alu_result,
    input  logic lsu_done,
    input  cdb_t lsu_result,
    output logic alu_grant,
    output logic lsu_grant,
    output cdb_t cdb
);

    typedef enum logic {
        LAST_ALU,
        LAST_LSU
    } last_t;

    last_t last_q;

    always_comb begin
        alu_grant = 1'b0;
        lsu_grant = 1'b0;
        if (rdy) begin
            if (alu_done && lsu_done) begin
                if (last_q == LAST_ALU) begin
                    lsu_grant = 1'b1;
                end else begin
                    alu_grant = 1'b1;
                end
            end else begin
                alu_grant = alu_done;
                lsu_grant = lsu_done;
            end
        end
    end

    // bus mux driving all zero when idle
    always_comb begin
        cdb = '0;
        if (alu_grant) begin
            cdb       = alu_result;
            cdb.valid = 1'b1;
        end else if (lsu_grant) begin
            cdb       = lsu_result;
            cdb.valid = 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            last_q <= LAST_LSU; // alu wins the first tie
        end else if (alu_grant || lsu_grant) begin
            last_q <= lsu_grant ? LAST_LSU : LAST_ALU;
        end
    end

endmodule

//--- src/exec_cluster.sv
`timescale 1ns/10ps

module exec_cluster
    import exec_types_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst,
    input  logic       rdy,
    input  logic       rob_clear,
    input  logic       issue_valid,
    input  issue_pkt_t issue_pkt,
    output logic       rs_full,
    input  lsu_req_t   lsu_req,
    output logic       lsu_busy,
    output cdb_t       cdb
);

    logic     alu_req_valid;
    alu_req_t alu_req;
    logic     alu_busy;
    logic     alu_done;
    cdb_t     alu_result;
    logic     alu_grant;
    logic     lsu_done;
    cdb_t     lsu_result;
    logic     lsu_grant;

    reservation_station rs_i (
        .clk_in        (clk_in),
        .rst           (rst),
        .rdy           (rdy),
        .rob_clear     (rob_clear),
        .issue_valid   (issue_valid),
        .issue_pkt     (issue_pkt),
        .cdb           (cdb),        // wakeup from the shared bus
        .alu_busy      (alu_busy),
        .rs_full       (rs_full),
        .alu_req_valid (alu_req_valid),
        .alu_req       (alu_req)
    );

    int_alu alu_i (
        .clk_in    (clk_in),
        .rst       (rst),
        .rdy       (rdy),
        .rob_clear (rob_clear),
        .req_valid (alu_req_valid),
        .req       (alu_req),
        .grant     (alu_grant),
        .done      (alu_done),
        .busy      (alu_busy),
        .result    (alu_result)
    );

    load_store_unit lsu_i (
        .clk_in    (clk_in),
        .rst       (rst),
        .rdy       (rdy),
        .rob_clear (rob_clear),
        .req       (lsu_req),
        .grant     (lsu_grant),
        .busy      (lsu_busy),
        .done      (lsu_done),
        .result    (lsu_result)
    );

    cdb_arbiter arb_i (
        .clk_in     (clk_in),
        .rst        (rst),
        .rdy        (rdy),
        .alu_done   (alu_done),
        .alu_result (alu_result),
        .lsu_done   (lsu_done),
        .lsu_result (lsu_result),
        .alu_grant  (alu_grant),
        .lsu_grant  (lsu_grant),
        .cdb        (cdb)
    );

endmodule

//--- test/exec_cluster_tb.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_cluster_tb
    import rv_op_pkg::*;
    import exec_types_pkg::*;
();

    localparam int NUM_TAGS   = 1 << `ROB_BITS;
    localparam int NEVER_TAG  = NUM_TAGS - 1; // kept out of the tag rotation
    localparam int WAIT_LIMIT = 200;

    logic       clk_in;
    logic       rst;
    logic       rdy;
    logic       rob_clear;
    logic       issue_valid;
    issue_pkt_t issue_pkt;
    logic       rs_full;
    lsu_req_t   lsu_req;
    logic       lsu_busy;
    cdb_t       cdb;

    // scoreboard indexed by rob tag
    logic [NUM_TAGS-1:0] pending;
    word_t               exp_value [NUM_TAGS];
    int                  arrival [NUM_TAGS];
    int                  pending_cnt;
    int                  cycle_cnt;
    int                  overlap_cnt; // cycles with both units holding a result
    word_t               mem_model [`LSU_MEM_WORDS];
    word_t               rng_state;
    rob_tag_t            next_tag;

    exec_cluster exec_cluster_i (
        .clk_in      (clk_in),
        .rst         (rst),
        .rdy         (rdy),
        .rob_clear   (rob_clear),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .rs_full     (rs_full),
        .lsu_req     (lsu_req),
        .lsu_busy    (lsu_busy),
        .cdb         (cdb)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, expected);
            fail_run("value mismatch");
        end
    endtask

    function automatic word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // RV32I integer semantics
    function automatic word_t alu_model(opcode_t op, funct3_t f3, logic alt, word_t a, word_t b);
        logic [4:0]  sh;
        logic [63:0] ext;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;
        case (f3)
            ADD:     return (op == OP_REG && alt) ? a + (~b + 32'd1) : a + b;
            SLL:     return a << sh;
            SLT:     return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            SLTU:    return {31'b0, a < b};
            XOR:     return a ^ b;
            SRL:     return alt ? ext[31:0] : a >> sh;
            OR:      return a | b;
            AND:     return a & b;
            default: return '0;
        endcase
    endfunction

    function automatic operand_t ready_opnd(word_t v);
        operand_t o;
        o.value   = v;
        o.waiting = 1'b0;
        o.tag     = '0;
        return o;
    endfunction

    function automatic operand_t waiting_opnd(rob_tag_t t);
        operand_t o;
        o.value   = 32'hdead_beef; // stale value that wakeup must replace
        o.waiting = 1'b1;
        o.tag     = t;
        return o;
    endfunction

    function automatic issue_pkt_t make_pkt(opcode_t op, funct3_t f3, logic alt,
                                            operand_t s1, operand_t s2, rob_tag_t dest);
        issue_pkt_t p;
        p.opcode = op;
        p.funct3 = f3;
        p.alt    = alt;
        p.src1   = s1;
        p.src2   = s2;
        p.dest   = dest;
        return p;
    endfunction

    // cdb monitor sampling at the rising edge
    always @(posedge clk_in) begin
        if (!rst) begin
            if (exec_cluster_i.alu_grant && exec_cluster_i.lsu_grant) begin
                fail_run("both units were granted the cdb in the same cycle");
            end
            if (exec_cluster_i.alu_done && exec_cluster_i.lsu_done) begin
                overlap_cnt++;
            end
            if (cdb.valid) begin
                if (!rdy) begin
                    fail_run("cdb carried a result while rdy was low");
                end
                if (!pending[cdb.tag]) begin
                    fail_run($sformatf("tag %0d appeared on the cdb without being expected",
                                       cdb.tag));
                end
                check_value($sformatf("cdb.value (tag %0d)", cdb.tag), cdb.value,
                            exp_value[cdb.tag]);
                pending[cdb.tag] = 1'b0;
                arrival[cdb.tag] = cycle_cnt;
                pending_cnt--;
            end
            cycle_cnt++;
        end
    end

    task automatic alloc_tag(output rob_tag_t t);
        int waited;
        waited = 0;
        t      = next_tag;
        while (pending[t]) begin
            @(negedge clk_in);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timeout waiting for a free rob tag");
        end
        next_tag = (next_tag == rob_tag_t'(NUM_TAGS - 2)) ? '0 : next_tag + 1'b1;
    endtask

    task automatic issue_packet(input issue_pkt_t pkt, input word_t expected);
        int waited;
        waited = 0;
        while (rs_full) begin
            issue_valid = 1'b0;
            @(negedge clk_in);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timeout waiting for rs_full to drop");
        end
        pending[pkt.dest]   = 1'b1;
        exp_value[pkt.dest] = expected;
        pending_cnt++;
        issue_pkt   = pkt;
        issue_valid = 1'b1;
        @(negedge clk_in);
        issue_valid = 1'b0;
    endtask

    task automatic lsu_access(input logic store, input lsu_addr_t addr, input word_t data,
                              input rob_tag_t dest);
        int waited;
        waited = 0;
        while (lsu_busy) begin
            lsu_req.valid = 1'b0;
            @(negedge clk_in);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timeout waiting for lsu_busy to drop");
        end
        if (store) begin
            mem_model[addr] = data;
        end else begin
            pending[dest]   = 1'b1;
            exp_value[dest] = mem_model[addr];
            pending_cnt++;
        end
        lsu_req.valid    = 1'b1;
        lsu_req.is_store = store;
        lsu_req.addr     = addr;
        lsu_req.data     = data;
        lsu_req.dest     = dest;
        @(negedge clk_in);
        lsu_req.valid = 1'b0;
        check_value("lsu_busy", word_t'(lsu_busy), word_t'(!store)); // loads occupy the unit
    endtask

    task automatic random_alu_op(input opcode_t op, input funct3_t f3, input logic alt);
        rob_tag_t t;
        word_t    a;
        word_t    b;
        alloc_tag(t);
        a = next_rand();
        b = next_rand();
        if (op == OP_IMM) begin
            if (f3 == SLL || f3 == SRL) begin
                b = {27'b0, b[4:0]}; // shamt
            end else begin
                b = {{20{b[11]}}, b[11:0]};
            end
        end
        issue_packet(make_pkt(op, f3, alt, ready_opnd(a), ready_opnd(b), t),
                     alu_model(op, f3, alt, a, b));
    endtask

    task automatic random_any_op();
        word_t r;
        r = next_rand();
        random_alu_op(r[4] ? OP_IMM : OP_REG, funct3_t'(r[2:0]), r[3]);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending_cnt != 0) begin
            @(negedge clk_in);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timeout waiting for outstanding results");
        end
        repeat (3) @(negedge clk_in);
    endtask

    task automatic independent_ops_test();
        for (int f = 0; f < 8; f++) begin
            random_alu_op(OP_REG, funct3_t'(f), 1'b0);
            random_alu_op(OP_IMM, funct3_t'(f), 1'b0);
        end
        random_alu_op(OP_REG, ADD, 1'b1); // sub
        random_alu_op(OP_REG, SRL, 1'b1); // sra
        random_alu_op(OP_IMM, SRL, 1'b1); // srai
        drain();
    endtask

    task automatic dependency_chain_test();
        rob_tag_t t [4];
        word_t    v [4];
        word_t    k [4];
        int       waited;
        for (int i = 0; i < 4; i++) begin
            k[i] = next_rand();
        end
        alloc_tag(t[0]);
        v[0] = alu_model(OP_REG, ADD, 1'b0, k[0], k[1]);
        issue_packet(make_pkt(OP_REG, ADD, 1'b0, ready_opnd(k[0]), ready_opnd(k[1]), t[0]), v[0]);
        alloc_tag(t[1]);
        v[1] = alu_model(OP_REG, XOR, 1'b0, v[0], k[2]);
        issue_packet(make_pkt(OP_REG, XOR, 1'b0, waiting_opnd(t[0]), ready_opnd(k[2]), t[1]),
                     v[1]);
        alloc_tag(t[2]);
        // issue the next link in the very cycle its producer is broadcast
        waited = 0;
        while (!(cdb.valid && cdb.tag == t[1])) begin
            @(negedge clk_in);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timeout waiting for the chain producer result");
        end
        v[2] = alu_model(OP_REG, ADD, 1'b1, k[3], v[1]);
        issue_packet(make_pkt(OP_REG, ADD, 1'b1, ready_opnd(k[3]), waiting_opnd(t[1]), t[2]),
                     v[2]);
        alloc_tag(t[3]);
        v[3] = alu_model(OP_IMM, SRL, 1'b1, v[2], 32'd7);
        issue_packet(make_pkt(OP_IMM, SRL, 1'b1, waiting_opnd(t[2]), ready_opnd(32'd7), t[3]),
                     v[3]);
        drain();
        for (int i = 1; i < 4; i++) begin
            check_value($sformatf("arrival order of chain link %0d", i),
                        word_t'(arrival[t[i]] > arrival[t[i-1]]), 32'd1);
        end
    endtask

    task automatic memory_test();
        lsu_addr_t addr [4];
        word_t     r;
        rob_tag_t  t;
        word_t     imm;
        for (int i = 0; i < 4; i++) begin
            r       = next_rand();
            addr[i] = {r[3:0], 2'(i)}; // distinct words
            lsu_access(1'b1, addr[i], next_rand(), '0);
        end
        for (int i = 0; i < 4; i++) begin
            alloc_tag(t);
            lsu_access(1'b0, addr[i], '0, t);
        end
        // consumer of the last load issued while the load is in flight
        r   = next_rand();
        imm = {{20{r[11]}}, r[11:0]};
        issue_packet(make_pkt(OP_IMM, ADD, 1'b0, waiting_opnd(t), ready_opnd(imm), next_tag),
                     mem_model[addr[3]] + imm);
        next_tag = (next_tag == rob_tag_t'(NUM_TAGS - 2)) ? '0 : next_tag + 1'b1;
        drain();
    endtask

    task automatic contention_test();
        rob_tag_t t;
        overlap_cnt = 0;
        for (int n = 0; n < 3; n++) begin
            alloc_tag(t);
            lsu_access(1'b0, lsu_addr_t'(next_rand()), '0, t);
            repeat (3) random_any_op(); // first one finishes with the load
        end
        drain();
        check_value("alu/lsu result overlap seen", word_t'(overlap_cnt > 0), 32'd1);
    endtask

    task automatic full_flush_test();
        rob_tag_t flushed [`RS_SIZE];
        word_t    a;
        word_t    b;
        for (int i = 0; i < `RS_SIZE; i++) begin
            alloc_tag(flushed[i]);
            issue_packet(make_pkt(OP_REG, OR, 1'b0, waiting_opnd(rob_tag_t'(NEVER_TAG)),
                                  ready_opnd(next_rand()), flushed[i]), '0);
        end
        check_value("rs_full", word_t'(rs_full), 32'd1);
        rob_clear = 1'b1;
        @(negedge clk_in);
        rob_clear = 1'b0;
        check_value("rs_full", word_t'(rs_full), 32'd0);
        for (int i = 0; i < `RS_SIZE; i++) begin
            pending[flushed[i]] = 1'b0; // any later sighting is an error
            pending_cnt--;
        end
        // broadcast the tag the flushed entries waited on
        a = next_rand();
        b = next_rand();
        issue_packet(make_pkt(OP_REG, AND, 1'b0, ready_opnd(a), ready_opnd(b),
                              rob_tag_t'(NEVER_TAG)), alu_model(OP_REG, AND, 1'b0, a, b));
        repeat (5) random_any_op();
        drain();
    endtask

    task automatic pause_test();
        rob_tag_t t;
        repeat (4) random_any_op();
        alloc_tag(t);
        lsu_access(1'b0, lsu_addr_t'(next_rand()), '0, t);
        rdy = 1'b0;
        repeat (20) @(negedge clk_in);
        check_value("results pending over pause", word_t'(pending_cnt > 0), 32'd1);
        rdy = 1'b1;
        drain();
    endtask

    initial begin
        rst              = 1'b1;
        rdy              = 1'b1;
        rob_clear        = 1'b0;
        issue_valid      = 1'b0;
        issue_pkt        = '0;
        lsu_req          = '0;
        pending          = '0;
        pending_cnt      = 0;
        cycle_cnt        = 0;
        overlap_cnt      = 0;
        rng_state        = 32'd61;
        next_tag         = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            exp_value[i] = '0;
            arrival[i]   = 0;
        end
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            mem_model[i] = '0; // lsu memory is zero after reset
        end
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        rst = 1'b0;
        @(negedge clk_in);
        check_value("rs_full", word_t'(rs_full), 32'd0);
        check_value("lsu_busy", word_t'(lsu_busy), 32'd0);

        independent_ops_test();
        dependency_chain_test();
        memory_test();
        contention_test();
        full_flush_test();
        pause_test();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- exec_cluster.f
+incdir+include
src/rv_op_pkg.sv
src/exec_types_pkg.sv
src/rs_entry_select.sv
src/reservation_station.sv
src/int_alu.sv
src/load_store_unit.sv
src/cdb_arbiter.sv
src/exec_cluster.sv
test/exec_cluster_tb.sv

//--- Bender.yml
package:
  name: exec_cluster

export_include_dirs:
  - include

sources:
  - src/rv_op_pkg.sv
  - src/exec_types_pkg.sv
  - src/rs_entry_select.sv
  - src/reservation_station.sv
  - src/int_alu.sv
  - src/load_store_unit.sv
  - src/cdb_arbiter.sv
  - src/exec_cluster.sv
  - target: test
    files:
      - test/exec_cluster_tb.sv
